//--- source/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Widths, bit 0 is the MSB as in the POWER books
`define DEC_INST_WIDTH   32
`define DEC_ADDR_WIDTH   64
`define DEC_PID_WIDTH    20
`define DEC_TID_WIDTH    16
`define DEC_MAJID_WIDTH  64
`define DEC_PRIM_WIDTH   6
`define DEC_XO_WIDTH     5
`define DEC_REG_WIDTH    5
`define DEC_OPCODE_WIDTH 12
`define DEC_BODY_WIDTH   21

// Field positions inside the instruction word
`define DEC_PRIM_POS     0
`define DEC_RA_POS       11
`define DEC_XO_POS       26
`define DEC_BODY_START   6
`define DEC_BODY_END     25
`define DEC_RC_FLAG_POS  31

`endif

//--- source/decodePkg.sv
`include "decode_macros.svh"

package decodePkg;

    // Field and identifier vectors, numbered from the MSB
    typedef logic [0:`DEC_INST_WIDTH-1]   instWord_t;
    typedef logic [0:`DEC_ADDR_WIDTH-1]   address_t;
    typedef logic [0:`DEC_PID_WIDTH-1]    pid_t;
    typedef logic [0:`DEC_TID_WIDTH-1]    tid_t;
    typedef logic [0:`DEC_MAJID_WIDTH-1]  majId_t;
    typedef logic [0:`DEC_PRIM_WIDTH-1]   primOpcode_t;
    typedef logic [0:`DEC_XO_WIDTH-1]     xo_t;
    typedef logic [0:`DEC_REG_WIDTH-1]    regField_t;
    typedef logic [0:`DEC_OPCODE_WIDTH-1] intOpcode_t;
    typedef logic [0:`DEC_BODY_WIDTH-1]   body_t;

    // Functional unit class sent to the backend
    typedef enum logic [2:0] {
        FX = 3'd0,  // Integer
        FP = 3'd1,  // Floating point
        VX = 3'd2,  // Vector
        CR = 3'd3,  // Condition register
        LS = 3'd4   // Load/store
    } funcUnit_t;

    // Bit 0 flags a write, bit 1 a read
    typedef enum logic [1:0] {
        NONE  = 2'b00,
        WRITE = 2'b01,
        READ  = 2'b10
    } regAccess_t;

    // Which of RT, RA, RB, RC an instruction touches
    typedef enum logic [2:0] {
        PAT_TAB  = 3'd0,  // T written, A and B read
        PAT_TAC  = 3'd1,  // T written, A and C read
        PAT_TB   = 3'd2,  // T written, B read
        PAT_TABC = 3'd3,  // T written, A B C read
        PAT_ISEL = 3'd4   // As PAT_TAB, RA of zero means no register
    } operandPattern_t;

endpackage

//--- source/aFormClassifier.sv
`timescale 1ns/1ps

module aFormClassifier (
    input  decodePkg::primOpcode_t     primOpcode_i,
    input  decodePkg::xo_t             xo_i,
    output decodePkg::intOpcode_t      intOpcode_o,
    output decodePkg::funcUnit_t       funcUnit_o,
    output decodePkg::operandPattern_t pattern_o,
    output logic                       legal_o
);
    import decodePkg::*;

    localparam primOpcode_t PRIM_INT        = 6'd31;
    localparam primOpcode_t PRIM_FP_DOUBLE  = 6'd63;
    localparam primOpcode_t PRIM_FP_SINGLE  = 6'd59;
    localparam xo_t         XO_ISEL         = 5'd15;
    localparam xo_t         XO_FSEL         = 5'd23;  // Double precision only
    localparam intOpcode_t  OPC_ISEL        = 12'd1;
    localparam intOpcode_t  OPC_DOUBLE_BASE = 12'd2;
    localparam intOpcode_t  OPC_SINGLE_BASE = 12'd14;

    intOpcode_t      fpOffset;   // Position of the XO within a floating family
    operandPattern_t fpPattern;
    logic            fpKnown;

    // Both floating families share the XO ordering and operand shapes
    always_comb begin
        fpKnown  = 1'b1;
        fpOffset = '0;
        case (xo_i)
            5'd21:   fpOffset = 12'd0;   // Add
            5'd20:   fpOffset = 12'd1;   // Subtract
            5'd25:   fpOffset = 12'd2;   // Multiply
            5'd18:   fpOffset = 12'd3;   // Divide
            5'd22:   fpOffset = 12'd4;   // Square root
            5'd24:   fpOffset = 12'd5;   // Reciprocal estimate
            5'd26:   fpOffset = 12'd6;   // Reciprocal sqrt estimate
            5'd29:   fpOffset = 12'd7;   // Multiply-add
            5'd28:   fpOffset = 12'd8;   // Multiply-subtract
            5'd31:   fpOffset = 12'd9;   // Negative multiply-add
            5'd30:   fpOffset = 12'd10;  // Negative multiply-subtract
            5'd23:   fpOffset = 12'd11;  // Select
            default: fpKnown  = 1'b0;
        endcase
    end

    always_comb begin
        case (xo_i)
            5'd25:                      fpPattern = PAT_TAC;   // Multiply uses FRC
            5'd22, 5'd24, 5'd26:        fpPattern = PAT_TB;    // Single source in FRB
            5'd29, 5'd28, 5'd31, 5'd30,
            5'd23:                      fpPattern = PAT_TABC;
            default:                    fpPattern = PAT_TAB;
        endcase
    end

    always_comb begin
        intOpcode_o = '0;
        funcUnit_o  = FX;
        pattern_o   = PAT_TAB;
        legal_o     = 1'b0;
        case (primOpcode_i)
            PRIM_INT: begin
                if (xo_i == XO_ISEL) begin
                    intOpcode_o = OPC_ISEL;
                    funcUnit_o  = CR;
                    pattern_o   = PAT_ISEL;
                    legal_o     = 1'b1;
                end
            end
            PRIM_FP_DOUBLE: begin
                if (fpKnown) begin
                    intOpcode_o = OPC_DOUBLE_BASE + fpOffset;
                    funcUnit_o  = FP;
                    pattern_o   = fpPattern;
                    legal_o     = 1'b1;
                end
            end
            PRIM_FP_SINGLE: begin
                if (fpKnown && (xo_i != XO_FSEL)) begin
                    intOpcode_o = OPC_SINGLE_BASE + fpOffset;
                    funcUnit_o  = FP;
                    pattern_o   = fpPattern;
                    legal_o     = 1'b1;
                end
            end
            default: begin
                legal_o = 1'b0;  // Not an A-form family we handle
            end
        endcase
    end

endmodule

//--- source/operandAccessDecoder.sv
`timescale 1ns/1ps

module operandAccessDecoder (
    input  decodePkg::operandPattern_t pattern_i,
    input  decodePkg::regField_t       ra_i,
    output logic                       rtIsReg_o,
    output logic                       raIsReg_o,
    output logic                       rbIsReg_o,
    output logic                       rcIsReg_o,
    output decodePkg::regAccess_t      rtAccess_o,
    output decodePkg::regAccess_t      raAccess_o,
    output decodePkg::regAccess_t      rbAccess_o,
    output decodePkg::regAccess_t      rcAccess_o
);
    import decodePkg::*;

    logic useT;
    logic useA;
    logic useB;
    logic useC;

    always_comb begin
        useT = 1'b1;  // Every A-form instruction has a target
        useA = 1'b0;
        useB = 1'b0;
        useC = 1'b0;
        case (pattern_i)
            PAT_TAB: begin
                useA = 1'b1;
                useB = 1'b1;
            end
            PAT_TAC: begin
                useA = 1'b1;
                useC = 1'b1;
            end
            PAT_TB:  useB = 1'b1;
            PAT_TABC: begin
                useA = 1'b1;
                useB = 1'b1;
                useC = 1'b1;
            end
            PAT_ISEL: begin
                useA = (ra_i != '0);  // RA of zero reads as constant zero
                useB = 1'b1;
            end
            default: useT = 1'b0;
        endcase
    end

    assign rtIsReg_o  = useT;
    assign raIsReg_o  = useA;
    assign rbIsReg_o  = useB;
    assign rcIsReg_o  = useC;
    assign rtAccess_o = useT ? WRITE : NONE;
    assign raAccess_o = useA ? READ : NONE;
    assign rbAccess_o = useB ? READ : NONE;
    assign rcAccess_o = useC ? READ : NONE;

endmodule

//--- source/decodeOutputRegister.sv
`timescale 1ns/1ps

module decodeOutputRegister (
    input  logic                   clock_i,
    input  logic                   rst_i,
    input  logic                   load_i,
    input  decodePkg::intOpcode_t  intOpcode_i,
    input  decodePkg::funcUnit_t   funcUnit_i,
    input  decodePkg::primOpcode_t primOpcode_i,
    input  decodePkg::xo_t         xo_i,
    input  decodePkg::body_t       body_i,
    input  decodePkg::address_t    address_i,
    input  decodePkg::pid_t        pid_i,
    input  decodePkg::tid_t        tid_i,
    input  decodePkg::majId_t      majId_i,
    input  logic                   rtIsReg_i,
    input  logic                   raIsReg_i,
    input  logic                   rbIsReg_i,
    input  logic                   rcIsReg_i,
    input  decodePkg::regAccess_t  rtAccess_i,
    input  decodePkg::regAccess_t  raAccess_i,
    input  decodePkg::regAccess_t  rbAccess_i,
    input  decodePkg::regAccess_t  rcAccess_i,
    output logic                   valid_o,
    output decodePkg::intOpcode_t  intOpcode_o,
    output decodePkg::funcUnit_t   funcUnit_o,
    output decodePkg::primOpcode_t primOpcode_o,
    output decodePkg::xo_t         xo_o,
    output decodePkg::body_t       body_o,
    output decodePkg::address_t    address_o,
    output decodePkg::pid_t        pid_o,
    output decodePkg::tid_t        tid_o,
    output decodePkg::majId_t      majId_o,
    output logic                   rtIsReg_o,
    output logic                   raIsReg_o,
    output logic                   rbIsReg_o,
    output logic                   rcIsReg_o,
    output decodePkg::regAccess_t  rtAccess_o,
    output decodePkg::regAccess_t  raAccess_o,
    output decodePkg::regAccess_t  rbAccess_o,
    output decodePkg::regAccess_t  rcAccess_o
);
    import decodePkg::*;

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            valid_o      <= 1'b0;
            intOpcode_o  <= '0;
            funcUnit_o   <= FX;
            primOpcode_o <= '0;
            xo_o         <= '0;
            body_o       <= '0;
            address_o    <= '0;
            pid_o        <= '0;
            tid_o        <= '0;
            majId_o      <= '0;
            rtIsReg_o    <= 1'b0;
            raIsReg_o    <= 1'b0;
            rbIsReg_o    <= 1'b0;
            rcIsReg_o    <= 1'b0;
            rtAccess_o   <= NONE;
            raAccess_o   <= NONE;
            rbAccess_o   <= NONE;
            rcAccess_o   <= NONE;
        end else begin
            valid_o <= load_i;  // One-cycle strobe per legal input
            if (load_i) begin
                intOpcode_o  <= intOpcode_i;
                funcUnit_o   <= funcUnit_i;
                primOpcode_o <= primOpcode_i;
                xo_o         <= xo_i;
                body_o       <= body_i;
                address_o    <= address_i;
                pid_o        <= pid_i;
                tid_o        <= tid_i;
                majId_o      <= majId_i;
                rtIsReg_o    <= rtIsReg_i;
                raIsReg_o    <= raIsReg_i;
                rbIsReg_o    <= rbIsReg_i;
                rcIsReg_o    <= rcIsReg_i;
                rtAccess_o   <= rtAccess_i;
                raAccess_o   <= raAccess_i;
                rbAccess_o   <= rbAccess_i;
                rcAccess_o   <= rcAccess_i;
            end
        end
    end

endmodule

//--- source/aFormDecoder.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module aFormDecoder (
    input  logic                   clock_i,
    input  logic                   rst_i,
    input  logic                   inValid_i,
    input  decodePkg::instWord_t   instruction_i,
    input  decodePkg::address_t    address_i,
    input  decodePkg::pid_t        pid_i,
    input  decodePkg::tid_t        tid_i,
    input  decodePkg::majId_t      majId_i,
    output logic                   valid_o,
    output decodePkg::intOpcode_t  intOpcode_o,
    output decodePkg::funcUnit_t   funcUnit_o,
    output decodePkg::primOpcode_t primOpcode_o,
    output decodePkg::xo_t         xo_o,
    output decodePkg::body_t       body_o,
    output decodePkg::address_t    address_o,
    output decodePkg::pid_t        pid_o,
    output decodePkg::tid_t        tid_o,
    output decodePkg::majId_t      majId_o,
    output logic                   rtIsReg_o,
    output logic                   raIsReg_o,
    output logic                   rbIsReg_o,
    output logic                   rcIsReg_o,
    output decodePkg::regAccess_t  rtAccess_o,
    output decodePkg::regAccess_t  raAccess_o,
    output decodePkg::regAccess_t  rbAccess_o,
    output decodePkg::regAccess_t  rcAccess_o
);
    import decodePkg::*;

    primOpcode_t     primOpcode;
    xo_t             xo;
    regField_t       raField;
    body_t           body;
    intOpcode_t      intOpcode;
    funcUnit_t       funcUnit;
    operandPattern_t pattern;
    logic            legal;
    logic            load;
    logic            rtIsReg;
    logic            raIsReg;
    logic            rbIsReg;
    logic            rcIsReg;
    regAccess_t      rtAccess;
    regAccess_t      raAccess;
    regAccess_t      rbAccess;
    regAccess_t      rcAccess;

    // Field slicing, POWER bit order
    assign primOpcode = instruction_i[`DEC_PRIM_POS +: `DEC_PRIM_WIDTH];
    assign xo         = instruction_i[`DEC_XO_POS +: `DEC_XO_WIDTH];
    assign raField    = instruction_i[`DEC_RA_POS +: `DEC_REG_WIDTH];
    assign body       = {instruction_i[`DEC_BODY_START:`DEC_BODY_END],
                         instruction_i[`DEC_RC_FLAG_POS]};  // Operands then Rc flag

    assign load = inValid_i & legal;  // Illegal words are dropped here

    aFormClassifier classifier (
        .primOpcode_i (primOpcode),
        .xo_i         (xo),
        .intOpcode_o  (intOpcode),
        .funcUnit_o   (funcUnit),
        .pattern_o    (pattern),
        .legal_o      (legal)
    );

    operandAccessDecoder operandDecoder (
        .pattern_i  (pattern),
        .ra_i       (raField),
        .rtIsReg_o  (rtIsReg),
        .raIsReg_o  (raIsReg),
        .rbIsReg_o  (rbIsReg),
        .rcIsReg_o  (rcIsReg),
        .rtAccess_o (rtAccess),
        .raAccess_o (raAccess),
        .rbAccess_o (rbAccess),
        .rcAccess_o (rcAccess)
    );

    decodeOutputRegister outputStage (
        .clock_i      (clock_i),
        .rst_i        (rst_i),
        .load_i       (load),
        .intOpcode_i  (intOpcode),
        .funcUnit_i   (funcUnit),
        .primOpcode_i (primOpcode),
        .xo_i         (xo),
        .body_i       (body),
        .address_i    (address_i),
        .pid_i        (pid_i),
        .tid_i        (tid_i),
        .majId_i      (majId_i),
        .rtIsReg_i    (rtIsReg),
        .raIsReg_i    (raIsReg),
        .rbIsReg_i    (rbIsReg),
        .rcIsReg_i    (rcIsReg),
        .rtAccess_i   (rtAccess),
        .raAccess_i   (raAccess),
        .rbAccess_i   (rbAccess),
        .rcAccess_i   (rcAccess),
        .valid_o      (valid_o),
        .intOpcode_o  (intOpcode_o),
        .funcUnit_o   (funcUnit_o),
        .primOpcode_o (primOpcode_o),
        .xo_o         (xo_o),
        .body_o       (body_o),
        .address_o    (address_o),
        .pid_o        (pid_o),
        .tid_o        (tid_o),
        .majId_o      (majId_o),
        .rtIsReg_o    (rtIsReg_o),
        .raIsReg_o    (raIsReg_o),
        .rbIsReg_o    (rbIsReg_o),
        .rcIsReg_o    (rcIsReg_o),
        .rtAccess_o   (rtAccess_o),
        .raAccess_o   (raAccess_o),
        .rbAccess_o   (rbAccess_o),
        .rcAccess_o   (rcAccess_o)
    );

endmodule

//--- dv/aFormDecoder_assertions.sv
`timescale 1ns/1ps

module aFormDecoder_assertions (
    input logic                 clock_i,
    input logic                 rst_i,
    input logic                 inValid_i,
    input logic                 valid_i,
    input decodePkg::funcUnit_t funcUnit_i,
    input logic [3:0]           isReg_i,   // RT RA RB RC
    input logic [7:0]           access_i   // RT RA RB RC, two bits each
);
    import decodePkg::*;

    validLowAfterReset: assert property (@(posedge clock_i) rst_i |=> !valid_i)
        else $error("valid_o high in the cycle after reset");

    validFollowsStrobe: assert property (@(posedge clock_i) disable iff (rst_i)
        valid_i |-> $past(inValid_i))
        else $error("valid_o without an input strobe one cycle earlier");

    // An operand that is no register has no access
    noAccessWhenUnused: assert property (@(posedge clock_i) disable iff (rst_i)
        valid_i |-> ((isReg_i[3] || access_i[7:6] == NONE) && (isReg_i[2] || access_i[5:4] == NONE)
            && (isReg_i[1] || access_i[3:2] == NONE) && (isReg_i[0] || access_i[1:0] == NONE)))
        else $error("Unused operand reports a register access");

    unitIsFpOrCr: assert property (@(posedge clock_i) disable iff (rst_i)
        valid_i |-> (funcUnit_i == FP || funcUnit_i == CR))
        else $error("Decoded unit is neither FP nor CR");

endmodule

bind aFormDecoder aFormDecoder_assertions assertions (
    .clock_i(clock_i), .rst_i(rst_i), .inValid_i(inValid_i), .valid_i(valid_o),
    .funcUnit_i(funcUnit_o), .isReg_i({rtIsReg_o, raIsReg_o, rbIsReg_o, rcIsReg_o}),
    .access_i({rtAccess_o, raAccess_o, rbAccess_o, rcAccess_o})
);

//--- dv/aFormDecoderTb.sv
`timescale 1ns/1ps

module aFormDecoderTb;
    import decodePkg::*;

    localparam int CLOCK_PERIOD   = 100;
    localparam int NUM_TESTS      = 5;
    localparam int WORDS_PER_TEST = 30;  // Longest test issues 25 words
    localparam int TIMEOUT_NS     = 2 * NUM_TESTS * WORDS_PER_TEST * CLOCK_PERIOD;

    // Floating XO order of the opcode table with the RA RB RC usage of each
    localparam logic [4:0] FP_XO_ORDER [12] = '{5'd21, 5'd20, 5'd25, 5'd18, 5'd22, 5'd24,
                                                5'd26, 5'd29, 5'd28, 5'd31, 5'd30, 5'd23};
    localparam logic [2:0] FP_OPERANDS [12] = '{3'b110, 3'b110, 3'b101, 3'b110, 3'b010, 3'b010,
                                                3'b010, 3'b111, 3'b111, 3'b111, 3'b111, 3'b111};

    logic clock;
    logic rst;
    logic inValid;
    instWord_t instruction;
    address_t address;
    pid_t pid;
    tid_t tid;
    majId_t majId;
    logic valid;
    intOpcode_t intOpcode;
    funcUnit_t funcUnit;
    primOpcode_t primOpcode;
    xo_t xo;
    body_t body;
    address_t addressOut;
    pid_t pidOut;
    tid_t tidOut;
    majId_t majIdOut;
    logic rtIsReg;
    logic raIsReg;
    logic rbIsReg;
    logic rcIsReg;
    regAccess_t rtAccess;
    regAccess_t raAccess;
    regAccess_t rbAccess;
    regAccess_t rcAccess;

    // Expected record that only a legal strobe updates
    logic expValid;
    logic [11:0] expOpcode;
    logic [2:0] expUnit;
    logic [5:0] expPrim;
    logic [4:0] expXo;
    logic [20:0] expBody;
    logic [63:0] expAddress;
    logic [19:0] expPid;
    logic [15:0] expTid;
    logic [63:0] expMajId;
    logic [3:0] expIsReg;   // RT RA RB RC
    logic [7:0] expAccess;  // RT RA RB RC, two bits each

    integer seed;
    int checkCount;
    int errorCount;
    int testStartErrors;

    aFormDecoder DUT (
        .clock_i(clock), .rst_i(rst), .inValid_i(inValid), .instruction_i(instruction),
        .address_i(address), .pid_i(pid), .tid_i(tid), .majId_i(majId),
        .valid_o(valid), .intOpcode_o(intOpcode), .funcUnit_o(funcUnit),
        .primOpcode_o(primOpcode), .xo_o(xo), .body_o(body), .address_o(addressOut),
        .pid_o(pidOut), .tid_o(tidOut), .majId_o(majIdOut),
        .rtIsReg_o(rtIsReg), .raIsReg_o(raIsReg), .rbIsReg_o(rbIsReg), .rcIsReg_o(rcIsReg),
        .rtAccess_o(rtAccess), .raAccess_o(raAccess), .rbAccess_o(rbAccess),
        .rcAccess_o(rcAccess)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] nextRandom();
        return $random(seed);
    endfunction

    // Opcode table and operand access rules of the A-form families
    function automatic logic referenceDecode(input logic [5:0] prim, input logic [4:0] xoIn,
            input logic [4:0] ra, output logic [11:0] opcode, output logic [2:0] unit,
            output logic [3:0] isReg, output logic [7:0] access);
        logic legal;
        logic [2:0] usedAbc;  // RA RB RC
        legal = 1'b0;
        opcode = '0;
        unit = 3'd0;
        usedAbc = 3'b000;
        if (prim == 6'd31 && xoIn == 5'd15) begin
            legal = 1'b1;
            opcode = 12'd1;
            unit = 3'd3;  // CR
            usedAbc = {ra != 5'd0, 2'b10};  // RA zero is no register
        end
        for (int i = 0; i < 12; i++) begin
            if ((prim == 6'd63 || prim == 6'd59) && xoIn == FP_XO_ORDER[i]
                    && !(prim == 6'd59 && xoIn == 5'd23)) begin
                legal = 1'b1;
                opcode = (prim == 6'd63) ? 12'(2 + i) : 12'(14 + i);
                unit = 3'd1;  // FP
                usedAbc = FP_OPERANDS[i];
            end
        end
        isReg = legal ? {1'b1, usedAbc} : 4'b0000;
        access = {isReg[3] ? 2'b01 : 2'b00, isReg[2] ? 2'b10 : 2'b00,
                  isReg[1] ? 2'b10 : 2'b00, isReg[0] ? 2'b10 : 2'b00};
        return legal;
    endfunction

    task automatic compare(input logic [63:0] actual, input logic [63:0] expected,
            input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic checkOutputs();
        compare(64'(valid), 64'(expValid), "valid_o");
        compare(64'(intOpcode), 64'(expOpcode), "intOpcode_o");
        compare(64'(funcUnit), 64'(expUnit), "funcUnit_o");
        compare(64'(primOpcode), 64'(expPrim), "primOpcode_o");
        compare(64'(xo), 64'(expXo), "xo_o");
        compare(64'(body), 64'(expBody), "body_o");
        compare(64'(addressOut), expAddress, "address_o");
        compare(64'(pidOut), 64'(expPid), "pid_o");
        compare(64'(tidOut), 64'(expTid), "tid_o");
        compare(64'(majIdOut), expMajId, "majId_o");
        compare(64'({rtIsReg, raIsReg, rbIsReg, rcIsReg}), 64'(expIsReg), "isReg flags");
        compare(64'({rtAccess, raAccess, rbAccess, rcAccess}), 64'(expAccess), "access fields");
    endtask

    // Checks the previous cycle's result, then drives the next word
    task automatic applyWord(input logic strobe, input logic [5:0] prim, input logic [4:0] xoIn,
            input logic [4:0] ra);
        logic [31:0] r;
        logic [31:0] r2;
        logic [11:0] opcode;
        logic [2:0] unit;
        logic [3:0] isReg;
        logic [7:0] access;
        logic legal;
        @(negedge clock);
        checkOutputs();
        r = nextRandom();
        r2 = nextRandom();
        inValid = strobe;
        instruction = {prim, r[4:0], ra, r[9:5], r[14:10], xoIn, r[15]};
        address = {nextRandom(), nextRandom()};
        pid = r2[31:12];
        tid = r[31:16];
        majId = {nextRandom(), nextRandom()};
        legal = referenceDecode(prim, xoIn, ra, opcode, unit, isReg, access);
        expValid = strobe && legal;
        if (expValid) begin
            expOpcode = opcode;
            expUnit = unit;
            expPrim = prim;
            expXo = xoIn;
            expBody = {r[4:0], ra, r[9:5], r[14:10], r[15]};  // RT RA RB RC Rc
            expAddress = address;
            expPid = pid;
            expTid = tid;
            expMajId = majId;
            expIsReg = isReg;
            expAccess = access;
        end
    endtask

    task automatic finishTest(input string name);
        applyWord(1'b0, 6'd0, 5'd0, 5'd0);  // Lets the last word reach the outputs
        $display("Test %s done with %0d mismatches", name, errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    task automatic testResetState();
        applyWord(1'b0, 6'd31, 5'd15, 5'd3);  // Legal words without a strobe
        applyWord(1'b0, 6'd63, 5'd29, 5'd3);
        applyWord(1'b0, 6'd59, 5'd21, 5'd3);
        finishTest("reset state");
    endtask

    task automatic testIntegerSelect();
        logic [31:0] r;
        r = nextRandom();
        applyWord(1'b1, 6'd31, 5'd15, r[4:0] | 5'd1);
        applyWord(1'b0, 6'd0, 5'd0, 5'd0);
        applyWord(1'b1, 6'd31, 5'd15, 5'd0);  // RA field of zero
        applyWord(1'b1, 6'd31, 5'd15, r[9:5] | 5'd4);
        finishTest("integer select");
    endtask

    task automatic testFloatTable(input logic [5:0] prim, input string name);
        logic [31:0] r;
        logic [4:0] ra;
        for (int i = 0; i < 12; i++) begin
            r = nextRandom();
            ra = (i % 3 == 0) ? 5'd0 : r[4:0];  // RA of zero stays a register here
            applyWord(1'b1, prim, FP_XO_ORDER[i], ra);
            applyWord(1'b0, prim, FP_XO_ORDER[i], ra);  // Same word with the strobe dropped
        end
        finishTest(name);
    endtask

    task automatic testIllegalAndBackToBack();
        logic [31:0] r;
        logic [11:0] opcode;
        logic [2:0] unit;
        logic [3:0] isReg;
        logic [7:0] access;
        int sent;
        sent = 0;
        applyWord(1'b1, 6'd31, 5'd14, 5'd3);  // Near misses first
        applyWord(1'b1, 6'd63, 5'd0, 5'd3);
        while (sent < 8) begin
            r = nextRandom();
            if (!referenceDecode(r[5:0], r[10:6], r[15:11], opcode, unit, isReg, access)) begin
                applyWord(1'b1, r[5:0], r[10:6], r[15:11]);
                sent++;
            end
        end
        for (int i = 0; i < 8; i++) begin
            r = nextRandom();
            if (r[1:0] == 2'd0) begin
                applyWord(1'b1, 6'd31, 5'd15, r[20:16]);
            end else begin
                applyWord(1'b1, (r[1:0] == 2'd1) ? 6'd63 : 6'd59, FP_XO_ORDER[r[7:4] % 11],
                          r[20:16]);
            end
        end
        finishTest("illegal and back-to-back");
    endtask

    initial begin
        seed = 32'h4e51_07c4;
        checkCount = 0;
        errorCount = 0;
        testStartErrors = 0;
        rst = 1'b1;
        inValid = 1'b0;
        instruction = '0;
        address = '0;
        pid = '0;
        tid = '0;
        majId = '0;
        {expValid, expOpcode, expUnit, expPrim, expXo, expBody} = '0;
        {expAddress, expPid, expTid, expMajId, expIsReg, expAccess} = '0;
        repeat (4) @(negedge clock);
        rst = 1'b0;
        testResetState();
        testIntegerSelect();
        testFloatTable(6'd63, "double-precision table");
        testFloatTable(6'd59, "single-precision table");
        testIllegalAndBackToBack();
        $display("Checks: %0d, mismatches: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not complete", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/decodePkg.sv
source/aFormClassifier.sv
source/operandAccessDecoder.sv
source/decodeOutputRegister.sv
source/aFormDecoder.sv
dv/aFormDecoder_assertions.sv
dv/aFormDecoderTb.sv

//--- run.sh
#!/bin/sh
# Builds the A-form decoder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
    --top-module aFormDecoderTb -Mdir "$BUILD_DIR" -o aFormDecoderSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/aFormDecoderSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
